// ==== common/fm_pkg.sv ====
// Phase section shared types
`default_nettype none

package fm_pkg;

	// Slot numbering, slot = operator * 6 + channel
	typedef logic [4:0] slot_t;
	typedef logic [2:0] chan_t;

	// Channel pitch settings
	typedef logic [10:0] fnum_t;
	typedef logic [2:0] block_t;

	// Operator settings
	typedef logic [3:0] mul_t;
	// Detune, bit 2 is the sign and bits 1..0 the amount
	typedef logic [2:0] dt1_t;

	// Block, fnum bit 10 and one rounding bit
	typedef logic [4:0] keycode_t;

	// Phase path widths
	typedef logic [16:0] phinc_t;
	typedef logic [19:0] phase_acc_t;
	typedef logic [9:0] phase_t;

	// Write port
	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Six channels of four operators
	localparam int slot_count = 24;
	localparam int chan_count = 6;

	//////////////////////////////////////////////////
	// Register map

	// Operator mask in 7..4, channel in 2..0
	localparam reg_addr_t addr_keyon = 8'h28;
	// Plus slot, detune in 6..4 and multiplier in 3..0
	localparam reg_addr_t addr_op_base = 8'h30;
	// Plus channel, low eight fnum bits
	localparam reg_addr_t addr_fnum_lo = 8'hA0;
	// Plus channel, block in 5..3 and fnum high bits in 2..0
	localparam reg_addr_t addr_fnum_hi = 8'hA8;

endpackage

`default_nettype wire

// ==== logic/slot_delay.sv ====
// Clocked delay line
`timescale 1ns/1ns
`default_nettype none

module slot_delay #(
	parameter int width = 1,
	parameter int stages = 1
) (
	input  wire              clk,
	input  wire              rst,
	input  wire [width-1:0]  din,
	output logic [width-1:0] drop
);

	// One register per stage, index 0 is the newest
	logic [width-1:0] sr [stages];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < stages; i++)
				sr[i] <= '0;
		end else begin
			sr[0] <= din;
			for (int i = 1; i < stages; i++)
				sr[i] <= sr[i-1];
		end
	end

	// Oldest value leaves here
	assign drop = sr[stages-1];

endmodule

`default_nettype wire

// ==== logic/slot_timer.sv ====
// Operator slot timer
`timescale 1ns/1ns
`default_nettype none

module slot_timer (
	input  wire            clk,
	input  wire            rst,
	output fm_pkg::slot_t  slot_cnt,
	output logic           zero,
	output fm_pkg::slot_t  kc_slot,
	output fm_pkg::slot_t  phase_slot
);

	//////////////////////////////////////////////////
	// Free-running slot counter

	always_ff @(posedge clk) begin
		if (rst)
			slot_cnt <= '0;
		else if (slot_cnt == fm_pkg::slot_t'(fm_pkg::slot_count - 1))
			slot_cnt <= '0;
		else
			slot_cnt <= slot_cnt + 5'd1;
	end

	// Start of a round
	assign zero = (slot_cnt == '0);

	//////////////////////////////////////////////////
	// Slots seen at the delayed outputs

	// Key code leaves two stages after stage I
	assign kc_slot = (slot_cnt >= 5'd2) ?
		slot_cnt - 5'd2 :
		slot_cnt + fm_pkg::slot_t'(fm_pkg::slot_count - 2);

	// Phase leaves seven stages after stage I
	assign phase_slot = (slot_cnt >= 5'd7) ?
		slot_cnt - 5'd7 :
		slot_cnt + fm_pkg::slot_t'(fm_pkg::slot_count - 7);

endmodule

`default_nettype wire

// ==== logic/fm_regs.sv ====
// Channel and operator registers
`timescale 1ns/1ns
`default_nettype none

module fm_regs (
	input  wire                clk,
	input  wire                rst,
	input  wire                wr,
	input  wire fm_pkg::reg_addr_t addr,
	input  wire fm_pkg::reg_data_t data,
	input  wire fm_pkg::slot_t slot_cnt,
	output fm_pkg::fnum_t      fnum,
	output fm_pkg::block_t     block,
	output fm_pkg::dt1_t       dt1,
	output fm_pkg::mul_t       mul,
	output logic               keyon
);

	// Per channel pitch
	fm_pkg::fnum_t  fnum_tab  [fm_pkg::chan_count];
	fm_pkg::block_t block_tab [fm_pkg::chan_count];
	// Per operator settings
	fm_pkg::dt1_t   dt1_tab   [fm_pkg::slot_count];
	fm_pkg::mul_t   mul_tab   [fm_pkg::slot_count];
	// Key level and key-on waiting for its slot
	logic [fm_pkg::slot_count-1:0] key_on;
	logic [fm_pkg::slot_count-1:0] key_pend;

	// Stage slots for II to V
	fm_pkg::slot_t slot_ii;
	fm_pkg::slot_t slot_iii;
	fm_pkg::slot_t slot_iv;
	fm_pkg::slot_t slot_v;
	fm_pkg::chan_t rd_chan;

	// Write decode
	fm_pkg::chan_t wr_chan;
	fm_pkg::chan_t kon_chan;
	fm_pkg::slot_t wr_slot;
	logic fnum_lo_hit;
	logic fnum_hi_hit;
	logic op_hit;
	logic kon_hit;

	//////////////////////////////////////////////////
	// Address decode

	assign wr_chan  = addr[2:0];
	assign kon_chan = data[2:0];
	assign wr_slot  = fm_pkg::slot_t'(addr - fm_pkg::addr_op_base);

	// Channels 6 and 7 fall through
	assign fnum_lo_hit = wr && (addr[7:3] == fm_pkg::addr_fnum_lo[7:3]) &&
		(int'(wr_chan) < fm_pkg::chan_count);
	assign fnum_hi_hit = wr && (addr[7:3] == fm_pkg::addr_fnum_hi[7:3]) &&
		(int'(wr_chan) < fm_pkg::chan_count);
	// 0x30 up to 0x47
	assign op_hit = wr && (addr >= fm_pkg::addr_op_base) &&
		(int'(addr) < int'(fm_pkg::addr_op_base) + fm_pkg::slot_count);
	assign kon_hit = wr && (addr == fm_pkg::addr_keyon) &&
		(int'(kon_chan) < fm_pkg::chan_count);

	//////////////////////////////////////////////////
	// Tables

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < fm_pkg::chan_count; c++) begin
				fnum_tab[c]  <= '0;
				block_tab[c] <= '0;
			end
			for (int s = 0; s < fm_pkg::slot_count; s++) begin
				dt1_tab[s] <= '0;
				mul_tab[s] <= '0;
			end
		end else begin
			if (fnum_lo_hit)
				fnum_tab[wr_chan][7:0] <= data;
			// High write carries block too
			if (fnum_hi_hit) begin
				fnum_tab[wr_chan][10:8] <= data[2:0];
				block_tab[wr_chan]      <= data[5:3];
			end
			if (op_hit) begin
				dt1_tab[wr_slot] <= data[6:4];
				mul_tab[wr_slot] <= data[3:0];
			end
		end
	end

	//////////////////////////////////////////////////
	// Key state

	always_ff @(posedge clk) begin
		if (rst) begin
			key_on   <= '0;
			key_pend <= '0;
		end else begin
			// Flag is used up once its slot passes stage II
			key_pend[slot_ii] <= 1'b0;
			if (kon_hit) begin
				// Mask bit 4 is operator 0
				for (int op = 0; op < 4; op++) begin
					key_on[op * fm_pkg::chan_count + int'(kon_chan)] <= data[4 + op];
					// Only a rising key restarts the phase
					if (data[4 + op] && !key_on[op * fm_pkg::chan_count + int'(kon_chan)])
						key_pend[op * fm_pkg::chan_count + int'(kon_chan)] <= 1'b1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Slot tracking

	// Reset values sit one round behind slot 0
	always_ff @(posedge clk) begin
		if (rst) begin
			slot_ii  <= fm_pkg::slot_t'(fm_pkg::slot_count - 1);
			slot_iii <= fm_pkg::slot_t'(fm_pkg::slot_count - 2);
			slot_iv  <= fm_pkg::slot_t'(fm_pkg::slot_count - 3);
			slot_v   <= fm_pkg::slot_t'(fm_pkg::slot_count - 4);
		end else begin
			slot_ii  <= slot_cnt;
			slot_iii <= slot_ii;
			slot_iv  <= slot_iii;
			slot_v   <= slot_iv;
		end
	end

	// Channel of the stage I slot
	assign rd_chan = fm_pkg::chan_t'(slot_cnt % fm_pkg::chan_count);

	// Read ports, each at its own stage
	assign fnum  = fnum_tab[rd_chan];
	assign block = block_tab[rd_chan];
	assign dt1   = dt1_tab[slot_ii];
	assign mul   = mul_tab[slot_v];
	assign keyon = key_pend[slot_ii];

endmodule

`default_nettype wire

// ==== phase/phase_gen.sv ====
// Phase increment and accumulator pipeline
`timescale 1ns/1ns
`default_nettype none

module phase_gen (
	input  wire                clk,
	input  wire                rst,
	input  wire fm_pkg::fnum_t  fnum,
	input  wire fm_pkg::block_t block,
	input  wire fm_pkg::dt1_t   dt1,
	input  wire fm_pkg::mul_t   mul,
	input  wire                keyon,
	output fm_pkg::keycode_t   keycode,
	output fm_pkg::phase_t     phase
);

	// Stage II
	fm_pkg::phinc_t   phinc_ii;
	fm_pkg::keycode_t keycode_ii;
	// Stage III
	fm_pkg::phinc_t   phinc_iii;
	fm_pkg::dt1_t     dt1_iii;
	logic [5:0]       dt1_kf_iii;
	// Stage III detune terms
	logic [4:0]       pow2;
	logic [4:0]       dt1_unlim;
	logic [4:0]       dt1_limit;
	// Stage IV
	fm_pkg::phinc_t   phinc_iv;
	fm_pkg::dt1_t     dt1_iv;
	logic [4:0]       dt1_offset_iv;
	// Stages V and VI
	fm_pkg::phinc_t   phinc_v;
	fm_pkg::phinc_t   phinc_vi;
	// Accumulator loop
	fm_pkg::phase_acc_t phase_in;
	fm_pkg::phase_acc_t phase_drop;
	logic             keyon_vi;
	fm_pkg::phase_t   phase_vii;

	//////////////////////////////////////////////////
	// Stage I

	always_ff @(posedge clk) begin
		if (rst) begin
			phinc_ii   <= '0;
			keycode_ii <= '0;
		end else begin
			// Block 0 halves fnum, block n shifts left by n-1
			if (block == 3'd0)
				phinc_ii <= {7'd0, fnum[10:1]};
			else
				phinc_ii <= fm_pkg::phinc_t'({6'd0, fnum} << (block - 3'd1));
			// Rounding bit from fnum 9..7
			keycode_ii <= {block, fnum[10], fnum[10] ? (|fnum[9:7]) : (&fnum[9:7])};
		end
	end

	//////////////////////////////////////////////////
	// Stage II

	always_ff @(posedge clk) begin
		if (rst) begin
			dt1_kf_iii <= '0;
			dt1_iii    <= '0;
			phinc_iii  <= '0;
			keycode    <= '0;
		end else begin
			// Detune table index
			case (dt1[1:0])
				2'd1:    dt1_kf_iii <= {1'b0, keycode_ii} - 6'd4;
				2'd2:    dt1_kf_iii <= {1'b0, keycode_ii} + 6'd4;
				2'd3:    dt1_kf_iii <= {1'b0, keycode_ii} + 6'd8;
				default: dt1_kf_iii <= {1'b0, keycode_ii};
			endcase
			dt1_iii   <= dt1;
			phinc_iii <= phinc_ii;
			keycode   <= keycode_ii;
		end
	end

	//////////////////////////////////////////////////
	// Stage III

	always_comb begin
		// Fractional power of two, low index bits
		case (dt1_kf_iii[2:0])
			3'd0:    pow2 = 5'd16;
			3'd1:    pow2 = 5'd17;
			3'd2:    pow2 = 5'd19;
			3'd3:    pow2 = 5'd20;
			3'd4:    pow2 = 5'd22;
			3'd5:    pow2 = 5'd24;
			3'd6:    pow2 = 5'd26;
			default: pow2 = 5'd29;
		endcase
		// Octave from the top index bits
		case (dt1_kf_iii[5:3])
			3'd0:    dt1_unlim = {4'd0, pow2[4]};
			3'd1:    dt1_unlim = {3'd0, pow2[4:3]};
			3'd2:    dt1_unlim = {2'd0, pow2[4:2]};
			3'd3:    dt1_unlim = {1'd0, pow2[4:1]};
			3'd4:    dt1_unlim = pow2;
			// Includes the wrapped negative index
			default: dt1_unlim = 5'd0;
		endcase
		// Ceiling per detune amount
		case (dt1_iii[1:0])
			2'd2:    dt1_limit = 5'd16;
			2'd3:    dt1_limit = 5'd22;
			default: dt1_limit = 5'd8;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dt1_offset_iv <= '0;
			dt1_iv        <= '0;
			phinc_iv      <= '0;
		end else begin
			if (dt1_unlim > dt1_limit)
				dt1_offset_iv <= dt1_limit;
			else
				dt1_offset_iv <= dt1_unlim;
			dt1_iv   <= dt1_iii;
			phinc_iv <= phinc_iii;
		end
	end

	//////////////////////////////////////////////////
	// Stage IV

	always_ff @(posedge clk) begin
		if (rst)
			phinc_v <= '0;
		else if (dt1_iv[1:0] == 2'd0)
			phinc_v <= phinc_iv;
		// Sign bit set subtracts
		else if (dt1_iv[2])
			phinc_v <= phinc_iv - {12'd0, dt1_offset_iv};
		else
			phinc_v <= phinc_iv + {12'd0, dt1_offset_iv};
	end

	//////////////////////////////////////////////////
	// Stage V

	always_ff @(posedge clk) begin
		if (rst)
			phinc_vi <= '0;
		// Multiplier 0 means one half
		else if (mul == 4'd0)
			phinc_vi <= {1'b0, phinc_v[16:1]};
		else
			phinc_vi <= phinc_v * {13'd0, mul};
	end

	//////////////////////////////////////////////////
	// Stage VI and output

	// Key-on restarts the slot from zero
	assign phase_in = keyon_vi ? '0 : phase_drop + {3'd0, phinc_vi};

	always_ff @(posedge clk) begin
		if (rst) begin
			phase_vii <= '0;
			phase     <= '0;
		end else begin
			phase_vii <= phase_in[19:10];
			phase     <= phase_vii;
		end
	end

	// One accumulator per slot, back after a full round
	slot_delay #(
		.width  (20),
		.stages (24)
	) u_phsh (
		.clk  (clk),
		.rst  (rst),
		.din  (phase_in),
		.drop (phase_drop)
	);

	// Key-on from stage II to stage VI
	slot_delay #(
		.width  (1),
		.stages (4)
	) u_konsh (
		.clk  (clk),
		.rst  (rst),
		.din  (keyon),
		.drop (keyon_vi)
	);

endmodule

`default_nettype wire

// ==== logic/fm_phase_top.sv ====
// FM phase section top
`timescale 1ns/1ns
`default_nettype none

module fm_phase_top (
	input  wire                    clk,
	input  wire                    rst,
	// Register writes
	input  wire                    wr,
	input  wire fm_pkg::reg_addr_t addr,
	input  wire fm_pkg::reg_data_t data,
	// Round start
	output logic                   zero,
	// Key code and its slot
	output fm_pkg::slot_t          kc_slot,
	output fm_pkg::keycode_t       keycode,
	// Phase and its slot
	output fm_pkg::slot_t          phase_slot,
	output fm_pkg::phase_t         phase
);

	// Stage I slot
	fm_pkg::slot_t  slot_cnt;
	// Register read-out into the pipeline
	fm_pkg::fnum_t  fnum;
	fm_pkg::block_t block;
	fm_pkg::dt1_t   dt1;
	fm_pkg::mul_t   mul;
	logic           keyon;

	slot_timer u_timer (
		.clk        (clk),
		.rst        (rst),
		.slot_cnt   (slot_cnt),
		.zero       (zero),
		.kc_slot    (kc_slot),
		.phase_slot (phase_slot)
	);

	fm_regs u_regs (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.addr     (addr),
		.data     (data),
		.slot_cnt (slot_cnt),
		.fnum     (fnum),
		.block    (block),
		.dt1      (dt1),
		.mul      (mul),
		.keyon    (keyon)
	);

	phase_gen u_pg (
		.clk     (clk),
		.rst     (rst),
		.fnum    (fnum),
		.block   (block),
		.dt1     (dt1),
		.mul     (mul),
		.keyon   (keyon),
		.keycode (keycode),
		.phase   (phase)
	);

endmodule

`default_nettype wire

// ==== sim/phase_model.svh ====
// Phase section reference model
`ifndef PHASE_MODEL_SVH
`define PHASE_MODEL_SVH

// Shadow register tables
logic [10:0] m_fnum [6];
logic [2:0] m_block [6];
logic [2:0] m_dt1 [24];
logic [3:0] m_mul [24];
logic m_key [24];
logic m_pend [24];

// Accumulators and per-slot values caught at each pipeline stage
logic [19:0] acc [24];
logic [16:0] cap_base [24];
logic [4:0] cap_kc [24];
logic [2:0] cap_dt1 [24];
logic [3:0] cap_mul [24];
logic cap_kon [24];
logic checked [24];

// Block 0 halves, block n scales by two to the n-1
function automatic logic [16:0] base_inc(input logic [10:0] fn, input logic [2:0] blk);
	logic [23:0] wide;
	if (blk == 3'd0)
		return 17'(fn) >> 1;
	wide = 24'(fn) * (24'd1 << (blk - 3'd1));
	return wide[16:0];
endfunction

function automatic logic [4:0] key_code(input logic [10:0] fn, input logic [2:0] blk);
	logic low_bit;
	// Upper half rounds up on any of bits 9..7, lower half only on all of them
	if (fn[10])
		low_bit = (fn[9:7] != 3'd0);
	else
		low_bit = (fn[9:7] == 3'd7);
	return {blk, fn[10], low_bit};
endfunction

// Fractional powers of two, 16 is one
function automatic int pow_value(input int i);
	case (i)
		0: return 16;
		1: return 17;
		2: return 19;
		3: return 20;
		4: return 22;
		5: return 24;
		6: return 26;
		default: return 29;
	endcase
endfunction

function automatic logic [16:0] detune_inc(input logic [16:0] inc, input logic [4:0] kc,
		input logic [2:0] d);
	int idx;
	int val;
	int cap;
	if (d[1:0] == 2'd0)
		return inc;
	idx = int'(kc) + ((d[1:0] == 2'd1) ? -4 : (d[1:0] == 2'd2) ? 4 : 8);
	// Index below zero gives no offset
	val = (idx < 0) ? 0 : (pow_value(idx % 8) << (idx / 8)) / 16;
	cap = (d[1:0] == 2'd1) ? 8 : (d[1:0] == 2'd2) ? 16 : 22;
	if (val > cap)
		val = cap;
	return d[2] ? inc - 17'(val) : inc + 17'(val);
endfunction

function automatic logic [16:0] mul_inc(input logic [16:0] inc, input logic [3:0] m);
	logic [20:0] wide;
	if (m == 4'd0)
		return inc >> 1;
	wide = 21'(inc) * 21'(m);
	return wide[16:0];
endfunction

`endif

// ==== sim/tb_fm_phase.sv ====
// FM phase section testbench
`timescale 1ns/1ns
`default_nettype none

module tb_fm_phase;

	logic clk;
	logic rst;
	logic wr;
	logic [7:0] addr;
	logic [7:0] data;
	logic zero;
	logic [4:0] kc_slot;
	logic [4:0] keycode;
	logic [4:0] phase_slot;
	logic [9:0] phase;

	int seed = 30;
	int errors = 0;
	int tests_ok = 0;
	int tests_bad = 0;
	// Stage I slot as counted here from the end of reset
	int slot_ref = 0;

	`include "phase_model.svh"

	fm_phase_top u_dut (
		.clk        (clk),
		.rst        (rst),
		.wr         (wr),
		.addr       (addr),
		.data       (data),
		.zero       (zero),
		.kc_slot    (kc_slot),
		.keycode    (keycode),
		.phase_slot (phase_slot),
		.phase      (phase)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////
	// Model update on register writes

	task automatic apply_write(input logic [7:0] a, input logic [7:0] d);
		int s;
		if (a == 8'h28 && d[2:0] < 3'd6) begin
			for (int op = 0; op < 4; op++) begin
				s = op * 6 + int'(d[2:0]);
				// Rising key only
				if (d[4 + op] && !m_key[s])
					m_pend[s] = 1'b1;
				m_key[s] = d[4 + op];
			end
		end else if (a >= 8'h30 && a < 8'h48) begin
			s = int'(a) - 'h30;
			m_dt1[s] = d[6:4];
			m_mul[s] = d[3:0];
			checked[s] = 1'b0;
		end else if (a[7:4] == 4'hA && a[2:0] < 3'd6) begin
			if (a[3])
				{m_block[a[2:0]], m_fnum[a[2:0]][10:8]} = d[5:0];
			else
				m_fnum[a[2:0]][7:0] = d;
			for (int op = 0; op < 4; op++)
				checked[op * 6 + int'(a[2:0])] = 1'b0;
		end
	endtask

	// Called 5 ns after a rising edge
	task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
		wr = 1'b1;
		addr = a;
		data = d;
		@(posedge clk);
		#5;
		wr = 1'b0;
		apply_write(a, d);
	endtask

	task automatic wait_zero(output int cycles);
		cycles = 0;
		while (!zero && cycles < 48) begin
			@(posedge clk);
			#5;
			cycles++;
		end
		if (!zero) begin
			$display("timeout: zero pulse did not arrive within 48 cycles");
			$display("test failed");
			$finish;
		end
	endtask

	task automatic wait_rounds(input int n);
		int c;
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#5;
			wait_zero(c);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d errors", name, errors - err_before);
		end
	endtask

	////////////////////////////////////////////////////
	// Per-cycle checker, sampled at the falling edge

	always @(negedge clk) begin : check_outputs
		int p;
		int s1;
		int s2;
		int s5;
		int k;
		logic [16:0] inc;
		if (rst) begin
			slot_ref = 0;
		end else begin
			// Stage I, II and V slots and the two output slots
			s1 = slot_ref;
			s2 = (slot_ref + 23) % 24;
			s5 = (slot_ref + 20) % 24;
			k = (slot_ref + 22) % 24;
			p = (slot_ref + 17) % 24;
			assert (zero == (slot_ref == 0)) else begin
				$display("mismatch t=%0t zero: got %0d expected %0d",
					$time, zero, slot_ref == 0);
				errors++;
			end
			assert (int'(kc_slot) == k) else begin
				$display("mismatch t=%0t kc_slot: got %0d expected %0d",
					$time, kc_slot, k);
				errors++;
			end
			assert (int'(phase_slot) == p) else begin
				$display("mismatch t=%0t phase_slot: got %0d expected %0d",
					$time, phase_slot, p);
				errors++;
			end
			// Slot leaving stage VIII
			inc = mul_inc(detune_inc(cap_base[p], cap_kc[p], cap_dt1[p]), cap_mul[p]);
			acc[p] = cap_kon[p] ? 20'd0 : acc[p] + {3'd0, inc};
			if (checked[p])
				assert (phase == acc[p][19:10]) else begin
					$display("mismatch t=%0t phase slot %0d: got %0d expected %0d",
						$time, p, phase, acc[p][19:10]);
					errors++;
				end
			checked[p] = 1'b1;
			assert (keycode == cap_kc[k]) else begin
				$display("mismatch t=%0t keycode slot %0d: got %0d expected %0d",
					$time, k, keycode, cap_kc[k]);
				errors++;
			end
			// Stage I, II and V reads
			cap_base[s1] = base_inc(m_fnum[s1 % 6], m_block[s1 % 6]);
			cap_kc[s1] = key_code(m_fnum[s1 % 6], m_block[s1 % 6]);
			cap_dt1[s2] = m_dt1[s2];
			cap_kon[s2] = m_pend[s2];
			m_pend[s2] = 1'b0;
			cap_mul[s5] = m_mul[s5];
			slot_ref = (slot_ref + 1) % 24;
		end
	end

	////////////////////////////////////////////////////
	// Stimulus

	initial begin : stimulus
		int c;
		int e;
		logic [10:0] fn;
		logic [2:0] blk;
		wr = 1'b0;
		addr = 8'h00;
		data = 8'h00;
		rst = 1'b1;
		for (int i = 0; i < 6; i++) begin
			m_fnum[i] = '0;
			m_block[i] = '0;
		end
		for (int s = 0; s < 24; s++) begin
			{m_dt1[s], m_mul[s], m_key[s], m_pend[s], acc[s]} = '0;
			{cap_base[s], cap_kc[s], cap_dt1[s], cap_mul[s], cap_kon[s]} = '0;
			checked[s] = 1'b1;
		end
		repeat (5) @(posedge clk);
		#5;
		rst = 1'b0;

		// Idle outputs and round timing
		e = errors;
		wait_zero(c);
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			#5;
			wait_zero(c);
			assert (c == 23) else begin
				$display("mismatch t=%0t zero period: got %0d expected 24", $time, c + 1);
				errors++;
			end
		end
		report_test("idle after reset", e);

		// Random pitch, detune 0 and multiplier 1
		e = errors;
		for (int s = 0; s < 24; s++)
			write_reg(8'h30 + 8'(s), 8'h01);
		for (int ch = 0; ch < 6; ch++) begin
			fn = 11'($random(seed));
			blk = 3'($random(seed));
			write_reg(8'hA0 + 8'(ch), fn[7:0]);
			write_reg(8'hA8 + 8'(ch), {2'b00, blk, fn[10:8]});
		end
		wait_rounds(4);
		report_test("random pitch", e);

		// Detune on a high and a low channel
		e = errors;
		write_reg(8'hA0, 8'hFF);
		write_reg(8'hA8, 8'h3F);
		write_reg(8'hA1, 8'hFF);
		write_reg(8'hA9, 8'h00);
		for (int d = 1; d < 8; d++) begin
			for (int op = 0; op < 4; op++) begin
				write_reg(8'h30 + 8'(op * 6), {1'b0, 3'(d), 4'd1});
				write_reg(8'h31 + 8'(op * 6), {1'b0, 3'(d), 4'd1});
			end
			wait_rounds(2);
		end
		report_test("detune", e);

		// Multipliers with 17-bit truncation
		e = errors;
		write_reg(8'hA2, 8'hFF);
		write_reg(8'hAA, 8'h3F);
		write_reg(8'h32, 8'h00);
		write_reg(8'h38, 8'h01);
		write_reg(8'h3E, 8'h05);
		write_reg(8'h44, 8'h0F);
		wait_rounds(3);
		report_test("multiplier", e);

		// Key-on with operators 0 and 2 on channel 3, then again
		e = errors;
		// Large increment so a restart shows in the top bits
		write_reg(8'hA3, 8'hFF);
		write_reg(8'hAB, 8'h3F);
		wait_rounds(1);
		write_reg(8'h28, 8'h53);
		wait_rounds(2);
		write_reg(8'h28, 8'h53);
		wait_rounds(2);
		report_test("key-on", e);

		$display("tests passed %0d failed %0d", tests_ok, tests_bad);
		if (tests_bad == 0 && errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+sim
common/fm_pkg.sv
logic/slot_delay.sv
logic/slot_timer.sv
logic/fm_regs.sv
phase/phase_gen.sv
logic/fm_phase_top.sv
sim/tb_fm_phase.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the FM phase testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_fm_phase -o tb_fm_phase \
	&& ./obj_dir/tb_fm_phase > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "test passed" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
